//--- source/except_pkg.sv
package except_pkg;

	// exception codes, MIPS32 values where the architecture gives one
	// interrupts carry a private nonzero code so that zero always means no event,
	// cp0_regs stores the architectural value 0 in Cause.ExcCode
	typedef enum logic [4:0] {
		NONE = 5'd0,
		MOD  = 5'd1,
		TLBL = 5'd2,
		TLBS = 5'd3,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		CPU  = 5'd11,
		OV   = 5'd12,
		TR   = 5'd13,
		INT  = 5'd31
	} exc_code_e;

	// cp0 register numbers, select folded to 0
	typedef enum logic [4:0] {
		BADVADDR  = 5'd8,
		STATUS    = 5'd12,
		CAUSE     = 5'd13,
		EPC       = 5'd14,
		EBASE     = 5'd15,
		ERROR_EPC = 5'd30
	} cp0_addr_e;

	// exception flag positions, lowest index has highest priority
	localparam int F_IADDR_ILLEGAL   = 0;
	localparam int F_IADDR_MISS      = 1;
	localparam int F_IADDR_INVALID   = 2;
	localparam int F_SYSCALL         = 3;
	localparam int F_BREAK           = 4;
	localparam int F_OVERFLOW        = 5;
	localparam int F_TRAP            = 6;
	localparam int F_ERET            = 7;
	localparam int F_PRIV_INST       = 8;
	localparam int F_INVALID_INST    = 9;
	// unaligned and illegal data addresses share this bit
	localparam int F_DADDR_UNALIGNED = 10;
	localparam int F_DADDR_MISS      = 11;
	localparam int F_DADDR_INVALID   = 12;
	localparam int F_DADDR_READONLY  = 13;
	localparam int EXC_FLAG_W        = F_DADDR_READONLY + 1;

	// status fields
	localparam int ST_IE    = 0;
	localparam int ST_EXL   = 1;
	localparam int ST_ERL   = 2;
	localparam int ST_UM    = 4;
	localparam int ST_IM_LO = 8;
	localparam int ST_BEV   = 22;

	// cause fields
	localparam int CA_CODE_LO = 2;
	localparam int CA_IP_LO   = 8;
	localparam int CA_IV      = 23;
	localparam int CA_BD      = 31;

	// exception vectors
	localparam logic [31:0] BEV_BASE    = 32'hbfc0_0200;
	localparam logic [11:0] OFS_REFILL  = 12'h000;
	localparam logic [11:0] OFS_GENERAL = 12'h180;
	localparam logic [11:0] OFS_IRQ     = 12'h200;

endpackage

//--- source/cp0_write_mask.sv
`timescale 1ns/1ns

module cp0_write_mask (
	input  except_pkg::cp0_addr_e addr,
	output logic [31:0]           mask
);

	always_comb begin
		case (addr)
			except_pkg::STATUS: begin
				mask = 32'd0;
				mask[except_pkg::ST_IE] = 1'b1;
				mask[except_pkg::ST_EXL] = 1'b1;
				mask[except_pkg::ST_ERL] = 1'b1;
				mask[except_pkg::ST_UM] = 1'b1;
				mask[except_pkg::ST_BEV] = 1'b1;
				// interrupt mask IM7..IM0
				mask[except_pkg::ST_IM_LO +: 8] = 8'hff;
			end
			except_pkg::CAUSE: begin
				mask = 32'd0;
				mask[except_pkg::CA_IV] = 1'b1;
				// only the two software interrupt bits
				mask[except_pkg::CA_IP_LO +: 2] = 2'b11;
			end
			except_pkg::EPC:       mask = 32'hffff_ffff;
			except_pkg::ERROR_EPC: mask = 32'hffff_ffff;
			// exception base, bits 29:12
			except_pkg::EBASE:     mask = 32'h3fff_f000;
			// BadVAddr is read only
			except_pkg::BADVADDR:  mask = 32'd0;
			default:               mask = 32'd0;
		endcase
	end

endmodule

//--- source/except.sv
`timescale 1ns/1ns

module except (
	input  logic                                rst_n,
	input  logic [31:0]                         pc_a,
	input  logic [31:0]                         pc_b,
	input  logic                                delayslot_a,
	input  logic                                delayslot_b,
	input  logic [except_pkg::EXC_FLAG_W-1:0]   flags_a,
	input  logic [except_pkg::EXC_FLAG_W-1:0]   flags_b,
	input  logic [31:0]                         data_vaddr,
	input  logic                                mem_we,
	input  logic                                user_mode,
	input  logic [7:0]                          interrupt_flag,
	input  logic                                cp0_we,
	input  except_pkg::cp0_addr_e               cp0_waddr,
	input  logic [31:0]                         cp0_wdata,
	input  logic [31:0]                         status_q,
	input  logic [31:0]                         cause_q,
	input  logic [31:0]                         epc_q,
	input  logic [31:0]                         error_epc_q,
	input  logic [31:0]                         ebase_q,
	output logic                                flush,
	output logic                                eret,
	output logic                                alpha_taken,
	output logic                                delayslot,
	output except_pkg::exc_code_e               code,
	output logic [31:0]                         cur_pc,
	output logic [31:0]                         jump_pc,
	output logic [31:0]                         extra
);

	logic [31:0] wmask;
	logic [31:0] wr_word;
	logic [31:0] status_v;
	logic [31:0] cause_v;
	logic [31:0] epc_v;
	logic [31:0] error_epc_v;
	logic [31:0] ebase_v;

	logic [except_pkg::EXC_FLAG_W-1:0] flags_any;
	logic                              irq_take;
	logic                              flag_hit;
	logic [3:0]                        win;
	logic                              eret_win;
	logic [31:0]                       slot_pc;
	except_pkg::exc_code_e             sel_code;
	logic [11:0]                       vec_ofs;
	logic [31:0]                       target;

	cp0_write_mask cp0_write_mask_i (
		.addr (cp0_waddr),
		.mask (wmask)
	);

	// writeback write merged in so this cycle sees the new cp0 state
	assign wr_word = cp0_wdata & wmask;

	always_comb begin
		status_v    = status_q;
		cause_v     = cause_q;
		epc_v       = epc_q;
		error_epc_v = error_epc_q;
		ebase_v     = ebase_q;
		if (cp0_we) begin
			case (cp0_waddr)
				except_pkg::STATUS:    status_v = wr_word | (status_q & ~wmask);
				except_pkg::CAUSE:     cause_v = wr_word | (cause_q & ~wmask);
				except_pkg::EPC:       epc_v = wr_word | (epc_q & ~wmask);
				except_pkg::ERROR_EPC: error_epc_v = wr_word | (error_epc_q & ~wmask);
				except_pkg::EBASE:     ebase_v = wr_word | (ebase_q & ~wmask);
				default: ;
			endcase
		end
	end

	assign irq_take = status_v[except_pkg::ST_IE] && !status_v[except_pkg::ST_EXL]
		&& !status_v[except_pkg::ST_ERL] && (interrupt_flag != 8'd0);

	always_comb begin
		flags_any = flags_a | flags_b;
		// privileged instructions fault only in user mode
		flags_any[except_pkg::F_PRIV_INST] = flags_any[except_pkg::F_PRIV_INST] & user_mode;
	end

	// lowest set flag wins
	always_comb begin
		flag_hit = 1'b0;
		win      = 4'd0;
		for (int i = 0; i < except_pkg::EXC_FLAG_W; i++) begin
			if (flags_any[i] && !flag_hit) begin
				flag_hit = 1'b1;
				win      = 4'(i);
			end
		end
	end

	// interrupts are taken on the older instruction
	assign alpha_taken = irq_take || (flag_hit && flags_a[win]);
	assign slot_pc     = alpha_taken ? pc_a : pc_b;
	assign delayslot   = alpha_taken ? delayslot_a : delayslot_b;
	assign eret_win    = !irq_take && flag_hit && (win == except_pkg::F_ERET);

	always_comb begin
		sel_code = except_pkg::NONE;
		extra    = 32'd0;
		if (irq_take) begin
			sel_code = except_pkg::INT;
			extra    = {24'd0, interrupt_flag};
		end else if (flag_hit) begin
			case (win)
				except_pkg::F_IADDR_ILLEGAL: begin
					sel_code = except_pkg::ADEL;
					extra    = slot_pc;
				end
				except_pkg::F_IADDR_MISS,
				except_pkg::F_IADDR_INVALID: begin
					sel_code = except_pkg::TLBL;
					extra    = slot_pc;
				end
				except_pkg::F_SYSCALL:      sel_code = except_pkg::SYS;
				except_pkg::F_BREAK:        sel_code = except_pkg::BP;
				except_pkg::F_OVERFLOW:     sel_code = except_pkg::OV;
				except_pkg::F_TRAP:         sel_code = except_pkg::TR;
				except_pkg::F_ERET:         sel_code = except_pkg::NONE;
				except_pkg::F_PRIV_INST: begin
					// coprocessor unit 1 unusable
					sel_code = except_pkg::CPU;
					extra    = 32'd1;
				end
				except_pkg::F_INVALID_INST: sel_code = except_pkg::RI;
				except_pkg::F_DADDR_UNALIGNED: begin
					sel_code = mem_we ? except_pkg::ADES : except_pkg::ADEL;
					extra    = data_vaddr;
				end
				except_pkg::F_DADDR_MISS,
				except_pkg::F_DADDR_INVALID: begin
					sel_code = mem_we ? except_pkg::TLBS : except_pkg::TLBL;
					extra    = data_vaddr;
				end
				except_pkg::F_DADDR_READONLY: begin
					sel_code = except_pkg::MOD;
					extra    = data_vaddr;
				end
				default: ;
			endcase
		end
	end

	// redirect target
	always_comb begin
		vec_ofs = except_pkg::OFS_GENERAL;
		if (!status_v[except_pkg::ST_EXL]) begin
			if (sel_code == except_pkg::TLBL || sel_code == except_pkg::TLBS)
				vec_ofs = except_pkg::OFS_REFILL;
			else if (sel_code == except_pkg::INT && cause_v[except_pkg::CA_IV])
				vec_ofs = except_pkg::OFS_IRQ;
		end
		if (eret_win)
			target = status_v[except_pkg::ST_ERL] ? error_epc_v : epc_v;
		else if (status_v[except_pkg::ST_BEV])
			target = except_pkg::BEV_BASE + {20'd0, vec_ofs};
		else
			target = {ebase_v[31:12], vec_ofs};
	end

	assign flush   = rst_n && (irq_take || flag_hit);
	// eret is only issued from pipe a
	assign eret    = flush && eret_win && flags_a[except_pkg::F_ERET];
	assign code    = flush ? sel_code : except_pkg::NONE;
	assign cur_pc  = flush ? slot_pc : 32'd0;
	assign jump_pc = flush ? target : 32'd0;

endmodule

//--- source/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs #(
	parameter logic [31:0] EBASE_RESET = 32'h8000_0000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cp0_we,
	input  except_pkg::cp0_addr_e cp0_waddr,
	input  logic [31:0]           cp0_wdata,
	input  logic                  flush,
	input  logic                  eret,
	input  except_pkg::exc_code_e code,
	input  logic [31:0]           cur_pc,
	input  logic                  delayslot,
	input  logic [31:0]           extra,
	input  except_pkg::cp0_addr_e cp0_raddr,
	input  logic [7:0]            interrupt_flag,
	output logic [31:0]           status_q,
	output logic [31:0]           cause_q,
	output logic [31:0]           epc_q,
	output logic [31:0]           error_epc_q,
	output logic [31:0]           ebase_q,
	output logic [31:0]           cp0_rdata
);

	// boot state, BEV and ERL set
	localparam logic [31:0] STATUS_RESET =
		(32'd1 << except_pkg::ST_BEV) | (32'd1 << except_pkg::ST_ERL);

	logic [31:0] wmask;
	logic [31:0] wr_word;
	logic [31:0] status_d;
	logic [31:0] cause_d;
	logic [31:0] epc_d;
	logic [31:0] error_epc_d;
	logic [31:0] ebase_d;
	logic [31:0] badvaddr_d;
	logic [31:0] badvaddr_q;
	logic        addr_fault;

	cp0_write_mask cp0_write_mask_i (
		.addr (cp0_waddr),
		.mask (wmask)
	);

	assign wr_word    = cp0_wdata & wmask;
	assign addr_fault = code inside {except_pkg::ADEL, except_pkg::ADES, except_pkg::TLBL,
		except_pkg::TLBS, except_pkg::MOD};

	always_comb begin
		status_d    = status_q;
		cause_d     = cause_q;
		epc_d       = epc_q;
		error_epc_d = error_epc_q;
		ebase_d     = ebase_q;
		badvaddr_d  = badvaddr_q;
		if (cp0_we) begin
			case (cp0_waddr)
				except_pkg::STATUS:    status_d = wr_word | (status_q & ~wmask);
				except_pkg::CAUSE:     cause_d = wr_word | (cause_q & ~wmask);
				except_pkg::EPC:       epc_d = wr_word | (epc_q & ~wmask);
				except_pkg::ERROR_EPC: error_epc_d = wr_word | (error_epc_q & ~wmask);
				except_pkg::EBASE:     ebase_d = wr_word | (ebase_q & ~wmask);
				default: ;
			endcase
		end
		// hardware interrupt lines, IP7..IP2
		cause_d[except_pkg::CA_IP_LO + 7 : except_pkg::CA_IP_LO + 2] = interrupt_flag[7:2];

		// exception entry wins over the writeback write
		if (flush && !eret) begin
			if (!status_d[except_pkg::ST_EXL])
				epc_d = delayslot ? cur_pc - 32'd4 : cur_pc;
			status_d[except_pkg::ST_EXL] = 1'b1;
			cause_d[except_pkg::CA_BD] = delayslot;
			cause_d[except_pkg::CA_CODE_LO +: 5] = (code == except_pkg::INT) ? 5'd0 : code;
			if (addr_fault)
				badvaddr_d = extra;
		end else if (eret) begin
			if (status_d[except_pkg::ST_ERL])
				status_d[except_pkg::ST_ERL] = 1'b0;
			else
				status_d[except_pkg::ST_EXL] = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_q    <= STATUS_RESET;
			cause_q     <= 32'd0;
			epc_q       <= 32'd0;
			error_epc_q <= 32'd0;
			ebase_q     <= EBASE_RESET;
		end else begin
			status_q    <= status_d;
			cause_q     <= cause_d;
			epc_q       <= epc_d;
			error_epc_q <= error_epc_d;
			ebase_q     <= ebase_d;
		end
	end

	always_ff @(posedge clk) begin
		badvaddr_q <= badvaddr_d;
	end

	always_comb begin
		case (cp0_raddr)
			except_pkg::BADVADDR:  cp0_rdata = badvaddr_q;
			except_pkg::STATUS:    cp0_rdata = status_q;
			except_pkg::CAUSE:     cp0_rdata = cause_q;
			except_pkg::EPC:       cp0_rdata = epc_q;
			except_pkg::EBASE:     cp0_rdata = ebase_q;
			except_pkg::ERROR_EPC: cp0_rdata = error_epc_q;
			default:               cp0_rdata = 32'd0;
		endcase
	end

endmodule

//--- source/except_unit.sv
`timescale 1ns/1ns

module except_unit #(
	parameter logic [31:0] EBASE_RESET = 32'h8000_0000
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [31:0]                       pc_a,
	input  logic [31:0]                       pc_b,
	input  logic                              delayslot_a,
	input  logic                              delayslot_b,
	input  logic [except_pkg::EXC_FLAG_W-1:0] flags_a,
	input  logic [except_pkg::EXC_FLAG_W-1:0] flags_b,
	input  logic [31:0]                       data_vaddr,
	input  logic                              mem_we,
	input  logic                              user_mode,
	input  logic [7:0]                        interrupt_flag,
	input  logic                              cp0_we,
	input  except_pkg::cp0_addr_e             cp0_waddr,
	input  logic [31:0]                       cp0_wdata,
	input  except_pkg::cp0_addr_e             cp0_raddr,
	output logic [31:0]                       cp0_rdata,
	output logic                              flush,
	output except_pkg::exc_code_e             code,
	output logic                              eret,
	output logic                              alpha_taken,
	output logic [31:0]                       cur_pc,
	output logic                              delayslot,
	output logic [31:0]                       jump_pc,
	output logic [31:0]                       extra
);

	logic [31:0] status_q;
	logic [31:0] cause_q;
	logic [31:0] epc_q;
	logic [31:0] error_epc_q;
	logic [31:0] ebase_q;

	except except_i (
		.rst_n, .pc_a, .pc_b, .delayslot_a, .delayslot_b, .flags_a, .flags_b,
		.data_vaddr, .mem_we, .user_mode, .interrupt_flag,
		.cp0_we, .cp0_waddr, .cp0_wdata,
		.status_q, .cause_q, .epc_q, .error_epc_q, .ebase_q,
		.flush, .eret, .alpha_taken, .delayslot, .code, .cur_pc, .jump_pc, .extra
	);

	cp0_regs #(
		.EBASE_RESET (EBASE_RESET)
	) cp0_regs_i (
		.clk, .rst_n, .cp0_we, .cp0_waddr, .cp0_wdata,
		.flush, .eret, .code, .cur_pc, .delayslot, .extra,
		.cp0_raddr, .interrupt_flag,
		.status_q, .cause_q, .epc_q, .error_epc_q, .ebase_q, .cp0_rdata
	);

endmodule

//--- testbench/except_unit_chk.sv
`timescale 1ns/1ns

module except_unit_chk (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  flush,
	input logic                  eret,
	input except_pkg::exc_code_e code,
	input logic [31:0]           status_q
);

	// a flush always carries an exception code or an eret
	flush_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
		flush |-> (code != except_pkg::NONE || eret))
		else $error("flush raised with no exception code and no eret");

	// eret leaves exception level on the next edge when ERL was clear
	eret_clears_exl: assert property (@(posedge clk) disable iff (!rst_n)
		(eret && !status_q[except_pkg::ST_ERL]) |=> !status_q[except_pkg::ST_EXL])
		else $error("Status.EXL still set after eret");

	// exception entry sets EXL on the next edge
	exl_after_entry: assert property (@(posedge clk) disable iff (!rst_n)
		(flush && !eret) |=> status_q[except_pkg::ST_EXL])
		else $error("Status.EXL not set after exception entry");

endmodule

bind except_unit except_unit_chk except_unit_chk_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.flush    (flush),
	.eret     (eret),
	.code     (code),
	.status_q (status_q)
);

//--- testbench/except_unit_tb.sv
`timescale 1ns/1ns

module except_unit_tb;

	localparam int W = except_pkg::EXC_FLAG_W;
	localparam int NUM_ROWS = 15;
	localparam logic [W-1:0] FL_IADDR = W'(1) << except_pkg::F_IADDR_ILLEGAL;
	localparam logic [W-1:0] FL_SYS   = W'(1) << except_pkg::F_SYSCALL;
	localparam logic [W-1:0] FL_BRK   = W'(1) << except_pkg::F_BREAK;
	localparam logic [W-1:0] FL_OV    = W'(1) << except_pkg::F_OVERFLOW;
	localparam logic [W-1:0] FL_ERET  = W'(1) << except_pkg::F_ERET;
	localparam logic [W-1:0] FL_PRIV  = W'(1) << except_pkg::F_PRIV_INST;
	localparam logic [W-1:0] FL_DMISS = W'(1) << except_pkg::F_DADDR_MISS;
	localparam logic [W-1:0] FL_DINV  = W'(1) << except_pkg::F_DADDR_INVALID;

	// x_kind 0 skip, 1 e_extra, 2 data_vaddr
	// rd_kind 0 none, 1 e_rd under rd_mask, 2 modelled EPC, 3 data_vaddr
	typedef struct {
		logic [W-1:0]          fa;
		logic [W-1:0]          fb;
		logic                  ds_a, ds_b, user, store;
		logic [7:0]            irq;
		logic                  we;
		except_pkg::cp0_addr_e waddr;
		logic [31:0]           wdata;
		logic                  e_flush;
		except_pkg::exc_code_e e_code;
		logic                  e_alpha, e_eret;
		logic [31:0]           e_jump;
		logic                  jump_epc;
		logic [1:0]            x_kind;
		logic [31:0]           e_extra;
		logic [1:0]            rd_kind;
		except_pkg::cp0_addr_e raddr;
		logic [31:0]           e_rd;
		logic [31:0]           rd_mask;
		logic                  epc_upd;
	} row_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] pc_a, pc_b, data_vaddr, cp0_wdata, cp0_rdata;
	logic delayslot_a, delayslot_b, mem_we, user_mode, cp0_we;
	logic [W-1:0] flags_a, flags_b;
	logic [7:0] interrupt_flag;
	except_pkg::cp0_addr_e cp0_waddr, cp0_raddr;
	logic flush, eret, alpha_taken, delayslot;
	except_pkg::exc_code_e code;
	logic [31:0] cur_pc, jump_pc, extra;

	row_t rows [NUM_ROWS];
	logic [31:0] lfsr = 32'd92;
	logic [31:0] epc_model = 32'd0;

	except_unit #(.EBASE_RESET(32'h8000_0000)) except_unit_i (.*);

	always #50 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic fb;
		logic [31:0] v;
		int i;
		v = 32'd0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic stop_on_error();
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_code(input string name, input except_pkg::exc_code_e got,
			input except_pkg::exc_code_e exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	initial begin
		#((NUM_ROWS * 2 + 4 + 2) * 100);
		$display("watchdog expired before all table rows were applied");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] exp_pc;
		logic [31:0] exp_jump;
		logic        ds;
		// erl still set, interrupt ignored, IP mirrors irq
		rows[0] = '{0, 0, 0, 0, 0, 0, 8'h04, 0, except_pkg::STATUS, 0,
			0, except_pkg::NONE, 0, 0, 0, 0, 2'd0, 0, 2'd1, except_pkg::CAUSE, 32'h0000_0400,
			32'hffff_ffff, 0};
		rows[1] = '{FL_SYS, FL_OV, 1, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::SYS, 1, 0, 32'hbfc0_0380, 0, 2'd0, 0, 2'd2, except_pkg::EPC, 0,
			32'hffff_ffff, 1};
		rows[2] = '{FL_BRK, FL_IADDR, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::ADEL, 0, 0, 32'hbfc0_0380, 0, 2'd0, 0, 2'd1, except_pkg::CAUSE,
			32'h0000_0010, 32'h8000_007c, 0};
		// erl set, eret goes to ErrorEPC
		rows[3] = '{FL_ERET, 0, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::NONE, 1, 1, 0, 0, 2'd0, 0, 2'd1, except_pkg::STATUS,
			32'h0040_0002, 32'hffff_ffff, 0};
		rows[4] = '{FL_ERET, 0, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::NONE, 1, 1, 0, 1, 2'd0, 0, 2'd1, except_pkg::STATUS,
			32'h0040_0000, 32'hffff_ffff, 0};
		// forwarded status write enables the interrupt
		rows[5] = '{0, 0, 0, 0, 0, 0, 8'h80, 1, except_pkg::STATUS, 32'h0040_ff01,
			1, except_pkg::INT, 1, 0, 32'hbfc0_0380, 0, 2'd1, 32'h80, 2'd1, except_pkg::CAUSE,
			32'h0000_8000, 32'hffff_ffff, 1};
		rows[6] = '{0, 0, 0, 0, 0, 0, 0, 1, except_pkg::STATUS, 32'h0000_ff01,
			0, except_pkg::NONE, 0, 0, 0, 0, 2'd0, 0, 2'd1, except_pkg::STATUS,
			32'h0000_ff01, 32'hffff_ffff, 0};
		rows[7] = '{0, 0, 0, 0, 0, 0, 0, 1, except_pkg::EBASE, 32'h9000_3000,
			0, except_pkg::NONE, 0, 0, 0, 0, 2'd0, 0, 2'd1, except_pkg::EBASE,
			32'h9000_3000, 32'hffff_ffff, 0};
		rows[8] = '{0, FL_DMISS, 0, 1, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::TLBL, 0, 0, 32'h9000_3000, 0, 2'd2, 0, 2'd3, except_pkg::BADVADDR,
			0, 32'hffff_ffff, 1};
		rows[9] = '{FL_DINV, 0, 0, 0, 0, 1, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::TLBS, 1, 0, 32'h9000_3180, 0, 2'd2, 0, 2'd1, except_pkg::CAUSE,
			32'h0000_000c, 32'h8000_007c, 0};
		rows[10] = '{FL_ERET, 0, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::NONE, 1, 1, 0, 1, 2'd0, 0, 2'd1, except_pkg::STATUS,
			32'h0000_ff01, 32'hffff_ffff, 0};
		// forwarded IV selects the interrupt vector
		rows[11] = '{0, 0, 0, 0, 0, 0, 8'h40, 1, except_pkg::CAUSE, 32'hffff_ffff,
			1, except_pkg::INT, 1, 0, 32'h9000_3200, 0, 2'd1, 32'h40, 2'd1, except_pkg::CAUSE,
			32'h0080_4300, 32'hffff_ffff, 1};
		rows[12] = '{FL_PRIV, 0, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			0, except_pkg::NONE, 0, 0, 0, 0, 2'd0, 0, 2'd0, except_pkg::STATUS, 0, 0, 0};
		rows[13] = '{0, FL_PRIV, 0, 0, 1, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::CPU, 0, 0, 32'h9000_3180, 0, 2'd1, 32'h1, 2'd1, except_pkg::CAUSE,
			32'h0000_002c, 32'h0000_007c, 0};
		rows[14] = '{FL_ERET, 0, 0, 0, 0, 0, 0, 0, except_pkg::STATUS, 0,
			1, except_pkg::NONE, 1, 1, 0, 1, 2'd0, 0, 2'd1, except_pkg::STATUS,
			32'h0000_ff01, 32'hffff_ffff, 0};

		rst_n = 1'b0;
		pc_a = 32'd0;
		pc_b = 32'd0;
		data_vaddr = 32'd0;
		delayslot_a = 1'b0;
		delayslot_b = 1'b0;
		flags_a = '0;
		flags_b = '0;
		mem_we = 1'b0;
		user_mode = 1'b0;
		interrupt_flag = 8'd0;
		cp0_we = 1'b0;
		cp0_waddr = except_pkg::STATUS;
		cp0_wdata = 32'd0;
		cp0_raddr = except_pkg::STATUS;
		repeat (4) @(posedge clk);
		#5 rst_n = 1'b1;

		foreach (rows[n]) begin
			@(posedge clk);
			#5;
			pc_a = rand_bits(32);
			pc_b = rand_bits(32);
			data_vaddr = rand_bits(32);
			flags_a = rows[n].fa;
			flags_b = rows[n].fb;
			delayslot_a = rows[n].ds_a;
			delayslot_b = rows[n].ds_b;
			user_mode = rows[n].user;
			mem_we = rows[n].store;
			interrupt_flag = rows[n].irq;
			cp0_we = rows[n].we;
			cp0_waddr = rows[n].waddr;
			cp0_wdata = rows[n].wdata;
			#80;
			exp_pc = rows[n].e_flush ? (rows[n].e_alpha ? pc_a : pc_b) : 32'd0;
			exp_jump = rows[n].jump_epc ? epc_model : rows[n].e_jump;
			// delay-slot bit of the slot that takes the event
			ds = rows[n].e_alpha ? rows[n].ds_a : rows[n].ds_b;
			check_bit("flush", flush, rows[n].e_flush);
			check_code("code", code, rows[n].e_code);
			check_bit("alpha_taken", alpha_taken, rows[n].e_alpha);
			check_bit("eret", eret, rows[n].e_eret);
			check_word("cur_pc", cur_pc, exp_pc);
			check_word("jump_pc", jump_pc, exp_jump);
			if (rows[n].e_flush)
				check_bit("delayslot", delayslot, ds);
			if (rows[n].x_kind == 2'd1)
				check_word("extra", extra, rows[n].e_extra);
			else if (rows[n].x_kind == 2'd2)
				check_word("extra", extra, data_vaddr);
			// EPC backs up one word for a delay slot
			if (rows[n].epc_upd)
				epc_model = ds ? exp_pc - 32'd4 : exp_pc;

			@(posedge clk);
			#5;
			flags_a = '0;
			flags_b = '0;
			interrupt_flag = 8'd0;
			cp0_we = 1'b0;
			cp0_raddr = rows[n].raddr;
			#80;
			check_bit("flush", flush, 1'b0);
			if (rows[n].rd_kind == 2'd1)
				check_word("cp0_rdata", cp0_rdata & rows[n].rd_mask, rows[n].e_rd);
			else if (rows[n].rd_kind == 2'd2)
				check_word("cp0_rdata", cp0_rdata, epc_model);
			else if (rows[n].rd_kind == 2'd3)
				check_word("cp0_rdata", cp0_rdata, data_vaddr);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- except_unit.f
source/except_pkg.sv
source/cp0_write_mask.sv
source/except.sv
source/cp0_regs.sv
source/except_unit.sv
testbench/except_unit_chk.sv
testbench/except_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the except_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f except_unit.f \
	--top-module except_unit_tb -o except_unit_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/except_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0
